//--- hw/jbus_wb_pkg.sv
//--------------------------------------------------------------------------
// shared widths, region map and request structs for the jbus/WISHBONE path
// word addressed bus; region field sits above the slave offset bits
// codes 2 and 3 are unmapped and answered by the decoder itself
//--------------------------------------------------------------------------
package jbus_wb_pkg;

	// bus geometry
	localparam int ADDR_WIDTH = 30;
	// 0:8bit 1:16bit 2:32bit
	localparam int DATA_SIZE  = 2;
	localparam int DATA_WIDTH = (8 << DATA_SIZE);
	localparam int SEL_WIDTH  = (DATA_WIDTH / 8);

	//--------------------------------------------------------------------------
	// address map
	//--------------------------------------------------------------------------
	// lowest bit of the two bit region field
	localparam int REGION_LSB = 10;

	localparam logic [1:0] REGION_SRAM = 2'd0;
	localparam logic [1:0] REGION_REGS = 2'd1;

	//--------------------------------------------------------------------------
	// request structs
	//--------------------------------------------------------------------------
	// one jbus request as presented by the pipeline master
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] wdata;
		logic                  we;
		logic [SEL_WIDTH-1:0]  sel;
		logic                  valid;
	} jbus_req_t;

	// one WISHBONE classic master request, no cyc
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] adr;
		logic [DATA_WIDTH-1:0] dat;
		logic                  we;
		logic [SEL_WIDTH-1:0]  sel;
		logic                  stb;
	} wb_req_t;

endpackage

//--- hw/jbus_to_wishbone.sv
//--------------------------------------------------------------------------
// jbus master port to WISHBONE classic bridge, one request in flight
// an ack seen while en_i is low is parked in a one word hold buffer
// no new strobe leaves the bridge until that word has been delivered
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module jbus_to_wishbone (
	input  logic                                 clk,
	input  logic                                 reset,

	// jbus side
	input  logic                                 en_i,
	input  jbus_wb_pkg::jbus_req_t               req_i,
	output logic [jbus_wb_pkg::DATA_WIDTH-1:0]   rdata_o,
	output logic                                 ready_o,

	// WISHBONE master side
	output jbus_wb_pkg::wb_req_t                 wb_req_o,
	input  logic                                 wb_ack_i,
	input  logic [jbus_wb_pkg::DATA_WIDTH-1:0]   wb_dat_i
);
	import jbus_wb_pkg::*;

	// hold buffer state
	logic                  hold_full;
	logic [DATA_WIDTH-1:0] hold_data;

	// request fields go straight through
	// strobe held off while a stalled read is parked
	always_comb begin
		wb_req_o.adr = req_i.addr;
		wb_req_o.dat = req_i.wdata;
		wb_req_o.we  = req_i.we;
		wb_req_o.sel = req_i.sel;
		wb_req_o.stb = req_i.valid & ~hold_full;
	end

	// idle bus or completing access
	assign ready_o = ~wb_req_o.stb | wb_ack_i;

	//--------------------------------------------------------------------------
	// hold buffer
	//--------------------------------------------------------------------------
	// set on ack during a stall, cleared by the next enabled edge
	always_ff @(posedge clk) begin
		if (reset) begin
			hold_full <= 1'b0;
		end else if (en_i) begin
			hold_full <= 1'b0;
		end else if (wb_req_o.stb & wb_ack_i) begin
			hold_full <= 1'b1;
		end
	end

	// capture slave data while stalled
	always_ff @(posedge clk) begin
		if (~en_i & wb_req_o.stb & wb_ack_i) begin
			hold_data <= wb_dat_i;
		end
	end

	//--------------------------------------------------------------------------
	// read data register
	//--------------------------------------------------------------------------
	// moves only with the pipeline
	// parked word wins over the live bus
	always_ff @(posedge clk) begin
		if (reset) begin
			rdata_o <= '0;
		end else if (en_i) begin
			rdata_o <= hold_full ? hold_data : wb_dat_i;
		end
	end

endmodule

//--- hw/wb_addr_decoder.sv
//--------------------------------------------------------------------------
// WISHBONE address decoder, purely combinational, zero added cycles
// region field picks the slave; unmapped regions ack at once with zero
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module wb_addr_decoder (
	// from the bridge
	input  jbus_wb_pkg::wb_req_t                 req_i,
	output logic                                 ack_o,
	output logic [jbus_wb_pkg::DATA_WIDTH-1:0]   dat_o,

	// to the slaves
	output jbus_wb_pkg::wb_req_t                 sram_req_o,
	output jbus_wb_pkg::wb_req_t                 regs_req_o,
	input  logic                                 sram_ack_i,
	input  logic [jbus_wb_pkg::DATA_WIDTH-1:0]   sram_dat_i,
	input  logic                                 regs_ack_i,
	input  logic [jbus_wb_pkg::DATA_WIDTH-1:0]   regs_dat_i
);
	import jbus_wb_pkg::*;

	logic [1:0] region;

	assign region = req_i.adr[REGION_LSB +: 2];

	//--------------------------------------------------------------------------
	// request fan out
	//--------------------------------------------------------------------------
	// both slaves see the full request
	// only the selected one sees a strobe
	always_comb begin
		sram_req_o     = req_i;
		sram_req_o.stb = req_i.stb & (region == REGION_SRAM);
		regs_req_o     = req_i;
		regs_req_o.stb = req_i.stb & (region == REGION_REGS);
	end

	//--------------------------------------------------------------------------
	// response merge
	//--------------------------------------------------------------------------
	always_comb begin
		case (region)
			REGION_SRAM: begin
				ack_o = sram_ack_i;
				dat_o = sram_dat_i;
			end
			REGION_REGS: begin
				ack_o = regs_ack_i;
				dat_o = regs_dat_i;
			end
			default: begin
				// unmapped, answer ourselves so the bus never hangs
				ack_o = req_i.stb;
				dat_o = '0;
			end
		endcase
	end

endmodule

//--- hw/wb_sram.sv
//--------------------------------------------------------------------------
// WISHBONE word SRAM, ack SRAM_WAIT cycles after strobe, SRAM_WAIT >= 1
// only the low SRAM_ADDR_BITS of the word address are decoded
// read data is zero outside the ack cycle; contents are not reset
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module wb_sram #(
	parameter int SRAM_ADDR_BITS = 8,
	parameter int SRAM_WAIT      = 2
) (
	input  logic                                 clk,
	input  logic                                 reset,
	input  jbus_wb_pkg::wb_req_t                 req_i,
	output logic                                 ack_o,
	output logic [jbus_wb_pkg::DATA_WIDTH-1:0]   dat_o
);
	import jbus_wb_pkg::*;

	localparam int WAIT_W = $clog2(SRAM_WAIT + 1);
	localparam int DEPTH  = 1 << SRAM_ADDR_BITS;

	logic [WAIT_W-1:0]         wait_cnt;
	logic [SRAM_ADDR_BITS-1:0] word_adr;
	logic [DATA_WIDTH-1:0]     mem [DEPTH];

	assign word_adr = req_i.adr[SRAM_ADDR_BITS-1:0];

	//--------------------------------------------------------------------------
	// wait state counter
	//--------------------------------------------------------------------------
	// restarts when the strobe drops or an access completes
	// so back-to-back strobes each see the full delay
	always_ff @(posedge clk) begin
		if (reset || !req_i.stb || ack_o) begin
			wait_cnt <= '0;
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// single cycle pulse, counter clears on the same edge
	assign ack_o = req_i.stb & (wait_cnt == WAIT_W'(SRAM_WAIT));

	//--------------------------------------------------------------------------
	// storage
	//--------------------------------------------------------------------------
	// write lands on the ack edge, per byte lane
	always_ff @(posedge clk) begin
		if (ack_o & req_i.we) begin
			for (int i = 0; i < SEL_WIDTH; i++) begin
				if (req_i.sel[i]) begin
					mem[word_adr][8*i +: 8] <= req_i.dat[8*i +: 8];
				end
			end
		end
	end

	// asynchronous read, driven only in the ack cycle of a read
	always_comb begin
		dat_o = '0;
		if (ack_o & ~req_i.we) begin
			dat_o = mem[word_adr];
		end
	end

endmodule

//--- hw/wb_scratch_regs.sv
//--------------------------------------------------------------------------
// four byte writable scratch words plus a read-only write counter
// offsets below the region field; other offsets read zero, ignore writes
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module wb_scratch_regs (
	input  logic                                 clk,
	input  logic                                 reset,
	input  jbus_wb_pkg::wb_req_t                 req_i,
	output logic                                 ack_o,
	output logic [jbus_wb_pkg::DATA_WIDTH-1:0]   dat_o
);
	import jbus_wb_pkg::*;

	// word offset of the counter
	localparam logic [REGION_LSB-1:0] CNT_OFS = REGION_LSB'(4);

	logic [REGION_LSB-1:0] offset;
	logic                  is_scratch;
	logic                  scratch_wr;
	logic [DATA_WIDTH-1:0] scratch [4];
	logic [DATA_WIDTH-1:0] wr_cnt;

	assign offset     = req_i.adr[REGION_LSB-1:0];
	// offsets 0 to 3
	assign is_scratch = (offset[REGION_LSB-1:2] == '0);

	// zero wait states
	assign ack_o      = req_i.stb;
	assign scratch_wr = ack_o & req_i.we & is_scratch;

	//--------------------------------------------------------------------------
	// register writes
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < 4; r++) begin
				scratch[r] <= '0;
			end
			wr_cnt <= '0;
		end else if (scratch_wr) begin
			for (int i = 0; i < SEL_WIDTH; i++) begin
				if (req_i.sel[i]) begin
					scratch[offset[1:0]][8*i +: 8] <= req_i.dat[8*i +: 8];
				end
			end
			// counts accesses, not lanes
			wr_cnt <= wr_cnt + 1'b1;
		end
	end

	// read mux, zero when idle
	always_comb begin
		dat_o = '0;
		if (ack_o & ~req_i.we) begin
			if (is_scratch) begin
				dat_o = scratch[offset[1:0]];
			end else if (offset == CNT_OFS) begin
				dat_o = wr_cnt;
			end
		end
	end

endmodule

//--- hw/jbus_wb_top.sv
//--------------------------------------------------------------------------
// jbus master port into a WISHBONE bus with SRAM and scratch registers
// region 0 SRAM, region 1 registers, regions 2 and 3 unmapped
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module jbus_wb_top #(
	parameter int SRAM_ADDR_BITS = 8,
	parameter int SRAM_WAIT      = 2
) (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 jbus_en_i,
	input  jbus_wb_pkg::jbus_req_t               jbus_req_i,
	output logic [jbus_wb_pkg::DATA_WIDTH-1:0]   jbus_rdata_o,
	output logic                                 jbus_ready_o
);
	import jbus_wb_pkg::*;

	// bridge to decoder
	wb_req_t               wb_req;
	logic                  wb_ack;
	logic [DATA_WIDTH-1:0] wb_dat;

	// decoder to slaves
	wb_req_t               sram_req;
	logic                  sram_ack;
	logic [DATA_WIDTH-1:0] sram_dat;
	wb_req_t               regs_req;
	logic                  regs_ack;
	logic [DATA_WIDTH-1:0] regs_dat;

	jbus_to_wishbone jbus_to_wishbone_inst (
		.clk      (clk),
		.reset    (reset),
		.en_i     (jbus_en_i),
		.req_i    (jbus_req_i),
		.rdata_o  (jbus_rdata_o),
		.ready_o  (jbus_ready_o),
		.wb_req_o (wb_req),
		.wb_ack_i (wb_ack),
		.wb_dat_i (wb_dat)
	);

	wb_addr_decoder wb_addr_decoder_inst (
		.req_i      (wb_req),
		.ack_o      (wb_ack),
		.dat_o      (wb_dat),
		.sram_req_o (sram_req),
		.regs_req_o (regs_req),
		.sram_ack_i (sram_ack),
		.sram_dat_i (sram_dat),
		.regs_ack_i (regs_ack),
		.regs_dat_i (regs_dat)
	);

	wb_sram #(
		.SRAM_ADDR_BITS (SRAM_ADDR_BITS),
		.SRAM_WAIT      (SRAM_WAIT)
	) wb_sram_inst (
		.clk   (clk),
		.reset (reset),
		.req_i (sram_req),
		.ack_o (sram_ack),
		.dat_o (sram_dat)
	);

	wb_scratch_regs wb_scratch_regs_inst (
		.clk   (clk),
		.reset (reset),
		.req_i (regs_req),
		.ack_o (regs_ack),
		.dat_o (regs_dat)
	);

endmodule

//--- verification/jbus_wb_tb.sv
//--------------------------------------------------------------------------
// directed testbench for the jbus to WISHBONE bridge with SRAM and registers
// SRAM words are read back only where a test wrote them first
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module jbus_wb_tb;
	import jbus_wb_pkg::*;

	localparam int SRAM_WAIT      = 2;
	// bus accesses issued by all tests together
	localparam int N_ACCESS       = 61;
	localparam int TIMEOUT_CYCLES = N_ACCESS * (SRAM_WAIT + 8) + 100;

	logic                  clk;
	logic                  reset;
	logic                  en;
	jbus_req_t             req;
	logic [DATA_WIDTH-1:0] rdata;
	logic                  ready;

	int                    errors;
	int                    seed;
	int                    reg_writes;
	logic [DATA_WIDTH-1:0] sram_model [256];
	logic [DATA_WIDTH-1:0] regs_model [4];

	jbus_wb_top #(
		.SRAM_ADDR_BITS (8),
		.SRAM_WAIT      (SRAM_WAIT)
	) jbus_wb_top_inst (
		.clk          (clk),
		.reset        (reset),
		.jbus_en_i    (en),
		.jbus_req_i   (req),
		.jbus_rdata_o (rdata),
		.jbus_ready_o (ready)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	//--------------------------------------------------------------------------
	// helpers
	//--------------------------------------------------------------------------
	task automatic check_value(input logic [DATA_WIDTH-1:0] actual,
			input logic [DATA_WIDTH-1:0] expected, input string msg);
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t: %s, got %h expected %h", $time, msg, actual, expected);
		end
	endtask

	function automatic logic [DATA_WIDTH-1:0] next_rand();
		return $random(seed);
	endfunction

	// word address from region code and offset below it
	function automatic logic [ADDR_WIDTH-1:0] region_addr(input logic [1:0] region,
			input logic [REGION_LSB-1:0] offset);
		return {{(ADDR_WIDTH-REGION_LSB-2){1'b0}}, region, offset};
	endfunction

	// selected lanes take the new byte, the rest keep the old one
	function automatic logic [DATA_WIDTH-1:0] merge_lanes(input logic [DATA_WIDTH-1:0] old_word,
			input logic [DATA_WIDTH-1:0] new_word, input logic [SEL_WIDTH-1:0] sel);
		logic [DATA_WIDTH-1:0] result;
		result = old_word;
		for (int i = 0; i < SEL_WIDTH; i++) begin
			if (sel[i]) begin
				result[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return result;
	endfunction

	// entered and left 1 ns after a rising edge
	task automatic bus_access(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] wdata,
			input logic we, input logic [SEL_WIDTH-1:0] sel, output logic [DATA_WIDTH-1:0] data);
		req.addr  = addr;
		req.wdata = wdata;
		req.we    = we;
		req.sel   = sel;
		req.valid = 1'b1;
		en        = 1'b1;
		// ready sampled mid cycle, accepted on the next edge
		@(negedge clk);
		while (!ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		req.valid = 1'b0;
		data      = rdata;
	endtask

	task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] wdata,
			input logic [SEL_WIDTH-1:0] sel);
		logic [DATA_WIDTH-1:0] unused;
		bus_access(addr, wdata, 1'b1, sel, unused);
	endtask

	task automatic read_check(input logic [ADDR_WIDTH-1:0] addr,
			input logic [DATA_WIDTH-1:0] expected, input string msg);
		logic [DATA_WIDTH-1:0] data;
		bus_access(addr, '0, 1'b0, 4'hf, data);
		check_value(data, expected, msg);
	endtask

	//--------------------------------------------------------------------------
	// tests
	//--------------------------------------------------------------------------
	task automatic test_reset_state();
		logic [DATA_WIDTH-1:0] first;
		@(negedge clk);
		check_value(32'(ready), 32'd1, "ready after reset");
		first = rdata;
		repeat (3) begin
			@(negedge clk);
			check_value(32'(ready), 32'd1, "ready while idle");
			check_value(rdata, first, "rdata moved while idle");
		end
		@(posedge clk);
		#1;
	endtask

	task automatic test_sram_round_trip();
		logic [7:0]            addrs [16];
		logic [DATA_WIDTH-1:0] word;
		for (int i = 0; i < 16; i++) begin
			word     = next_rand();
			addrs[i] = word[7:0];
			word     = next_rand();
			write_word(region_addr(REGION_SRAM, {2'b00, addrs[i]}), word, 4'hf);
			sram_model[addrs[i]] = word;
		end
		for (int i = 0; i < 16; i++) begin
			read_check(region_addr(REGION_SRAM, {2'b00, addrs[i]}), sram_model[addrs[i]],
				"sram round trip");
		end
	endtask

	task automatic test_byte_lanes();
		logic [SEL_WIDTH-1:0]  sels [4];
		logic [DATA_WIDTH-1:0] word;
		// full word first, then single and mixed lanes
		sels = '{4'hf, 4'h1, 4'h4, 4'ha};
		for (int i = 0; i < 4; i++) begin
			word = next_rand();
			write_word(region_addr(REGION_SRAM, 10'h080), word, sels[i]);
			sram_model[8'h80] = merge_lanes(sram_model[8'h80], word, sels[i]);
			read_check(region_addr(REGION_SRAM, 10'h080), sram_model[8'h80], "sram byte lanes");
		end
	endtask

	task automatic test_scratch_regs();
		logic [DATA_WIDTH-1:0] word;
		logic [SEL_WIDTH-1:0]  sel;
		for (int r = 0; r < 4; r++) begin
			word = next_rand();
			// offset 2 gets a partial write
			sel  = (r == 2) ? 4'b0110 : 4'hf;
			write_word(region_addr(REGION_REGS, 10'(r)), word, sel);
			regs_model[r] = merge_lanes(regs_model[r], word, sel);
			reg_writes++;
		end
		for (int r = 0; r < 4; r++) begin
			read_check(region_addr(REGION_REGS, 10'(r)), regs_model[r], "scratch readback");
		end
		read_check(region_addr(REGION_REGS, 10'd4), 32'(reg_writes), "write count");
		// counter itself is read only
		write_word(region_addr(REGION_REGS, 10'd4), next_rand(), 4'hf);
		read_check(region_addr(REGION_REGS, 10'd4), 32'(reg_writes), "count after write to it");
	endtask

	task automatic test_unmapped();
		read_check(region_addr(2'd2, 10'h000), '0, "unmapped read region 2");
		read_check(region_addr(2'd3, 10'h3ff), '0, "unmapped read region 3");
		// offsets that alias a known SRAM word and scratch word
		write_word(region_addr(2'd2, 10'h080), next_rand(), 4'hf);
		write_word(region_addr(2'd3, 10'h001), next_rand(), 4'hf);
		read_check(region_addr(REGION_SRAM, 10'h080), sram_model[8'h80], "sram after unmapped");
		read_check(region_addr(REGION_REGS, 10'h001), regs_model[1], "regs after unmapped");
		read_check(region_addr(REGION_REGS, 10'd4), 32'(reg_writes), "count after unmapped");
	endtask

	task automatic test_stall_read();
		logic [DATA_WIDTH-1:0] held;
		sram_model[8'h81] = next_rand();
		write_word(region_addr(REGION_SRAM, 10'h081), sram_model[8'h81], 4'hf);
		held = rdata;
		// read presented with the pipeline stalled
		en        = 1'b0;
		req.addr  = region_addr(REGION_SRAM, 10'h080);
		req.wdata = '0;
		req.we    = 1'b0;
		req.sel   = 4'hf;
		req.valid = 1'b1;
		@(negedge clk);
		while (!ready) begin
			@(negedge clk);
		end
		// ack edge passed, word parked and strobe masked
		repeat (4) begin
			@(negedge clk);
			check_value(32'(ready), 32'd1, "ready while word is held");
			check_value(rdata, held, "rdata moved during stall");
		end
		@(posedge clk);
		#1;
		en = 1'b1;
		@(posedge clk);
		#1;
		check_value(rdata, sram_model[8'h80], "held read data");
		// back to back, valid never drops
		read_check(region_addr(REGION_SRAM, 10'h081), sram_model[8'h81], "read after stall");
	endtask

	//--------------------------------------------------------------------------
	// watchdog and main sequence
	//--------------------------------------------------------------------------
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, an access never completed, errors: %0d",
			TIMEOUT_CYCLES, errors);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		clk        = 1'b0;
		reset      = 1'b1;
		en         = 1'b0;
		req        = '0;
		errors     = 0;
		reg_writes = 0;
		seed       = 32'h73a3_deb6;
		// scratch words reset to zero
		for (int r = 0; r < 4; r++) begin
			regs_model[r] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		en    = 1'b1;
		test_reset_state();
		test_sram_round_trip();
		test_byte_lanes();
		test_scratch_regs();
		test_unmapped();
		test_stall_read();
		$display("run complete, errors: %0d", errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
hw/jbus_wb_pkg.sv
hw/jbus_to_wishbone.sv
hw/wb_addr_decoder.sv
hw/wb_sram.sv
hw/wb_scratch_regs.sv
hw/jbus_wb_top.sv
verification/jbus_wb_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module jbus_wb_tb -f all.f -Mdir obj_dir -o jbus_wb_sim \
	&& ./obj_dir/jbus_wb_sim > sim.log 2>&1 \
	|| { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
test -s sim.log && ! grep -q "CHECKS FAILED" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
